// ==== compile.f ====
+incdir+hdl
hdl/rv_isa_pkg.sv
hdl/cpu_ctrl_pkg.sv
hdl/fetch_stage.sv
hdl/decode_unit.sv
hdl/regfile.sv
hdl/execute_stage.sv
hdl/mem_writeback.sv
hdl/riscv_core.sv
bench/riscv_core_asserts.sv
bench/riscv_core_tb.sv

// ==== bench/riscv_core_tb.sv ====
`timescale 1ns/1ps
`include "cpu_config.svh"

module riscv_core_tb;

    logic                         clk;
    logic                         rst_i;
    logic                         imem_we_i;
    logic [`CORE_IMEM_AWIDTH-1:0] imem_addr_i;
    rv_isa_pkg::word_t            imem_wdata_i;
    rv_isa_pkg::word_t            csr_o;
    logic                         csr_we_o;

    rv_isa_pkg::word_t prog [$];              // program words
    rv_isa_pkg::word_t expect_q [$];          // csr stream in order
    rv_isa_pkg::word_t model [32];            // register values under sequential execution
    rv_isa_pkg::word_t mem_model [rv_isa_pkg::word_t];
    int errors = 0;
    int pulses = 0;
    int reset_pulses = 0;
    int cycles = 0;
    int limit = 0;

    riscv_core uut (
        .clk(clk), .rst_i(rst_i),
        .imem_we_i(imem_we_i), .imem_addr_i(imem_addr_i), .imem_wdata_i(imem_wdata_i),
        .csr_o(csr_o), .csr_we_o(csr_we_o)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic rv_isa_pkg::word_t sext12(logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    function automatic rv_isa_pkg::word_t i_type(logic [11:0] imm, rv_isa_pkg::reg_addr_t rs1,
            rv_isa_pkg::funct3_t f3, rv_isa_pkg::reg_addr_t rd, rv_isa_pkg::opcode_t opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    task automatic set_reg(rv_isa_pkg::reg_addr_t rd, rv_isa_pkg::word_t v);
        if (rd != 5'd0)
            model[rd] = v;
    endtask

    task automatic addi(rv_isa_pkg::reg_addr_t rd, rv_isa_pkg::reg_addr_t rs1, logic [11:0] imm);
        prog.push_back(i_type(imm, rs1, 3'b000, rd, rv_isa_pkg::OP_IMM));
        set_reg(rd, model[rs1] + sext12(imm));
    endtask

    task automatic alu_rr(logic [6:0] f7, rv_isa_pkg::funct3_t f3, rv_isa_pkg::reg_addr_t rd,
            rv_isa_pkg::reg_addr_t rs1, rv_isa_pkg::reg_addr_t rs2);
        rv_isa_pkg::word_t a;
        rv_isa_pkg::word_t b;
        rv_isa_pkg::word_t r;
        a = model[rs1];
        b = model[rs2];
        case (f3)
            3'b000:  r = f7[5] ? a - b : a + b;
            3'b010:  r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b100:  r = a ^ b;
            3'b110:  r = a | b;
            default: r = a & b;
        endcase
        prog.push_back({f7, rs2, rs1, f3, rd, rv_isa_pkg::OP});
        set_reg(rd, r);
    endtask

    task automatic lui(rv_isa_pkg::reg_addr_t rd, logic [19:0] imm);
        prog.push_back({imm, rd, rv_isa_pkg::LUI});
        set_reg(rd, {imm, 12'b0});
    endtask

    task automatic sw(rv_isa_pkg::reg_addr_t rs2, rv_isa_pkg::reg_addr_t rs1, logic [11:0] imm);
        prog.push_back({imm[11:5], rs2, rs1, 3'b010, imm[4:0], rv_isa_pkg::STORE});
        mem_model[model[rs1] + sext12(imm)] = model[rs2];
    endtask

    task automatic lw(rv_isa_pkg::reg_addr_t rd, rv_isa_pkg::reg_addr_t rs1, logic [11:0] imm);
        prog.push_back(i_type(imm, rs1, 3'b010, rd, rv_isa_pkg::LOAD));
        set_reg(rd, mem_model[model[rs1] + sext12(imm)]);
    endtask

    // tohost write of rs1 that is expected only on the executed path
    task automatic csr_out(rv_isa_pkg::reg_addr_t rs1, logic visible);
        prog.push_back(i_type(`CORE_TOHOST_CSR, rs1, 3'b001, 5'd0, rv_isa_pkg::SYSTEM));
        if (visible)
            expect_q.push_back(model[rs1]);
    endtask

    // branch by +8 over one probe csr write
    task automatic branch_over(logic is_bne, rv_isa_pkg::reg_addr_t rs1,
            rv_isa_pkg::reg_addr_t rs2, rv_isa_pkg::reg_addr_t probe);
        logic taken;
        taken = is_bne ? (model[rs1] != model[rs2]) : (model[rs1] == model[rs2]);
        prog.push_back({7'b0, rs2, rs1, 2'b00, is_bne, 5'b01000, rv_isa_pkg::BRANCH});
        csr_out(probe, !taken);
    endtask

    task automatic jal_over(rv_isa_pkg::reg_addr_t rd, rv_isa_pkg::reg_addr_t probe);
        rv_isa_pkg::word_t link;
        link = 32'(prog.size()) * 4 + 4;
        prog.push_back({1'b0, 10'd4, 1'b0, 8'd0, rd, rv_isa_pkg::JAL});
        set_reg(rd, link);
        csr_out(probe, 1'b0);  // always squashed
    endtask

    task automatic build_program();
        foreach (model[i])
            model[i] = '0;
        addi(1, 0, 12'($urandom));
        addi(2, 0, 12'($urandom));
        addi(3, 1, 12'($urandom));
        csr_out(1, 1);
        csr_out(2, 1);
        csr_out(3, 1);
        alu_rr(7'h00, 3'b000, 4, 1, 2);   // add
        csr_out(4, 1);
        alu_rr(7'h20, 3'b000, 5, 1, 3);   // sub
        csr_out(5, 1);
        alu_rr(7'h00, 3'b111, 6, 1, 2);
        csr_out(6, 1);
        alu_rr(7'h00, 3'b110, 7, 1, 2);
        csr_out(7, 1);
        alu_rr(7'h00, 3'b100, 8, 2, 3);
        csr_out(8, 1);
        addi(10, 0, 12'hffb);                            // -5
        addi(11, 0, 12'd3);
        alu_rr(7'h00, 3'b010, 12, 10, 11);
        csr_out(12, 1);
        alu_rr(7'h00, 3'b010, 13, 11, 10);
        csr_out(13, 1);
        alu_rr(7'h00, 3'b010, 9, 1, 2);
        csr_out(9, 1);
        lui(14, 20'habcde);
        csr_out(14, 1);
        // dependency chain at distances 1, 2 and 3
        addi(15, 0, 12'd7);
        addi(16, 15, 12'd1);
        addi(20, 0, 12'd0);
        addi(17, 16, 12'd2);
        addi(20, 0, 12'd0);
        addi(20, 0, 12'd0);
        addi(18, 17, 12'd3);
        csr_out(16, 1);
        csr_out(17, 1);
        csr_out(18, 1);
        addi(19, 18, 12'hfff);
        csr_out(19, 1);
        addi(21, 0, 12'h040);
        sw(4, 21, 12'd8);
        lw(22, 21, 12'd8);                               // load-use
        csr_out(22, 1);
        sw(5, 21, 12'd12);
        lw(23, 21, 12'd12);
        alu_rr(7'h00, 3'b000, 24, 23, 22);
        csr_out(24, 1);
        branch_over(1'b0, 1, 1, 11);
        branch_over(1'b1, 1, 1, 11);
        branch_over(1'b1, 10, 11, 12);
        branch_over(1'b0, 10, 11, 12);
        jal_over(25, 11);
        csr_out(25, 1);
        prog.push_back({20'd0, 5'd0, rv_isa_pkg::JAL});  // jump to self
    endtask

    task automatic check_word(string name, rv_isa_pkg::word_t got, rv_isa_pkg::word_t exp);
        if (got !== exp) begin
            errors++;
            $display("ERR %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_count(string name, int got, int exp);
        if (got != exp) begin
            errors++;
            $display("ERR %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic finish_run();
        int asrt;
        asrt = uut.u_asserts.fail_cnt;
        $display("check errors: %0d, assertion errors: %0d", errors, asrt);
        if (errors == 0 && asrt == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    endtask

    always @(negedge clk) begin
        if (csr_we_o === 1'b1) begin
            if (rst_i)
                reset_pulses++;
            else
                pulses++;
        end
    end

    initial begin
        wait (limit != 0);
        while (cycles < limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("run timed out after %0d cycles", cycles);
        errors++;
        finish_run();
    end

    initial begin
        rst_i        = 1'b1;
        imem_we_i    = 1'b0;
        imem_addr_i  = '0;
        imem_wdata_i = '0;
        void'($urandom(32'hee4cd3be));
        build_program();
        limit = 4 * prog.size() + 100;
        repeat (2) @(negedge clk);
        foreach (prog[i]) begin
            @(negedge clk);
            imem_we_i    <= 1'b1;
            imem_addr_i  <= i[`CORE_IMEM_AWIDTH-1:0];
            imem_wdata_i <= prog[i];
        end
        @(negedge clk);
        imem_we_i <= 1'b0;
        repeat (2) @(negedge clk);
        rst_i <= 1'b0;
        foreach (expect_q[i]) begin
            do
                @(negedge clk);
            while (csr_we_o !== 1'b1);
            check_word("csr_o", csr_o, expect_q[i]);
        end
        repeat (20) @(negedge clk);  // sits in the jal loop by now
        check_count("csr_we_o pulses", pulses, expect_q.size());
        check_count("csr_we_o pulses in reset", reset_pulses, 0);
        finish_run();
    end

endmodule

// ==== bench/riscv_core_asserts.sv ====
`timescale 1ns/1ps

module riscv_core_asserts (
    input logic              clk,
    input logic              rst_i,
    input logic              csr_we_i,
    input rv_isa_pkg::word_t pc_i
);

    int fail_cnt = 0;  // assertion failures so far

    // strobe quiet in reset and for the first cycle after it
    assert property (@(posedge clk) rst_i |=> (!csr_we_i) [*2])
        else begin
            fail_cnt++;
            $error("csr write strobe high during or right after reset");
        end

    assert property (@(posedge clk) disable iff (rst_i) pc_i[1:0] == 2'b00)
        else begin
            fail_cnt++;
            $error("fetch pc not word aligned");
        end

    assert property (@(posedge clk) disable iff (rst_i) !$isunknown(csr_we_i))
        else begin
            fail_cnt++;
            $error("csr write strobe unknown after reset");
        end

endmodule

bind riscv_core riscv_core_asserts u_asserts (
    .clk(clk), .rst_i(rst_i), .csr_we_i(csr_we_o), .pc_i(pc_d)
);

// ==== hdl/riscv_core.sv ====
`timescale 1ns/1ps
`include "cpu_config.svh"

module riscv_core (
    input  logic                         clk,
    input  logic                         rst_i,
    input  logic                         imem_we_i,
    input  logic [`CORE_IMEM_AWIDTH-1:0] imem_addr_i,
    input  rv_isa_pkg::word_t            imem_wdata_i,
    output rv_isa_pkg::word_t            csr_o,
    output logic                         csr_we_o
);

    // fetch to decode
    rv_isa_pkg::word_t      inst;
    rv_isa_pkg::word_t      pc_d;

    // decode to execute
    rv_isa_pkg::reg_addr_t  ra1;
    rv_isa_pkg::reg_addr_t  ra2;
    rv_isa_pkg::reg_addr_t  rd;
    rv_isa_pkg::word_t      imm;
    rv_isa_pkg::word_t      rd1;
    rv_isa_pkg::word_t      rd2;
    cpu_ctrl_pkg::alu_op_t  alu_op;
    logic                   b_sel_imm;
    cpu_ctrl_pkg::br_kind_t br_kind;
    cpu_ctrl_pkg::wb_sel_t  wb_sel;
    logic                   reg_we;
    logic                   mem_we;
    logic                   csr_we;

    logic                   redirect;
    rv_isa_pkg::word_t      target;

    // execute to write-back
    rv_isa_pkg::word_t      alu_res;
    rv_isa_pkg::word_t      store_data;
    rv_isa_pkg::word_t      pc4;
    rv_isa_pkg::reg_addr_t  rd_x;
    cpu_ctrl_pkg::wb_sel_t  wb_sel_x;
    logic                   reg_we_x;
    logic                   mem_we_x;
    logic                   csr_we_x;

    // write-back to regfile and forwarding
    logic                   wb_we;
    rv_isa_pkg::reg_addr_t  wb_addr;
    rv_isa_pkg::word_t      wb_data;

    fetch_stage u_fetch (
        .clk(clk), .rst_i(rst_i),
        .redirect_i(redirect), .target_i(target),
        .imem_we_i(imem_we_i), .imem_addr_i(imem_addr_i), .imem_wdata_i(imem_wdata_i),
        .inst_o(inst), .pc_o(pc_d)
    );

    decode_unit u_decode (
        .inst_i(inst),
        .ra1_o(ra1), .ra2_o(ra2), .rd_o(rd), .imm_o(imm),
        .alu_op_o(alu_op), .b_sel_imm_o(b_sel_imm),
        .br_kind_o(br_kind), .wb_sel_o(wb_sel),
        .reg_we_o(reg_we), .mem_we_o(mem_we), .csr_we_o(csr_we)
    );

    regfile u_rf (
        .clk(clk),
        .ra1_i(ra1), .ra2_i(ra2), .rd1_o(rd1), .rd2_o(rd2),
        .we_i(wb_we), .wa_i(wb_addr), .wd_i(wb_data)
    );

    execute_stage u_execute (
        .clk(clk), .rst_i(rst_i),
        .pc_i(pc_d), .rd1_i(rd1), .rd2_i(rd2), .imm_i(imm),
        .ra1_i(ra1), .ra2_i(ra2), .rd_i(rd),
        .alu_op_i(alu_op), .b_sel_imm_i(b_sel_imm),
        .br_kind_i(br_kind), .wb_sel_i(wb_sel),
        .reg_we_i(reg_we), .mem_we_i(mem_we), .csr_we_i(csr_we),
        .wb_we_i(wb_we), .wb_addr_i(wb_addr), .wb_data_i(wb_data),
        .redirect_o(redirect), .target_o(target),
        .alu_res_o(alu_res), .store_data_o(store_data), .pc4_o(pc4),
        .rd_o(rd_x), .wb_sel_o(wb_sel_x),
        .reg_we_o(reg_we_x), .mem_we_o(mem_we_x), .csr_we_o(csr_we_x)
    );

    mem_writeback u_mem_wb (
        .clk(clk), .rst_i(rst_i),
        .alu_res_i(alu_res), .store_data_i(store_data), .pc4_i(pc4),
        .rd_i(rd_x), .wb_sel_i(wb_sel_x),
        .reg_we_i(reg_we_x), .mem_we_i(mem_we_x), .csr_we_i(csr_we_x),
        .wb_we_o(wb_we), .wb_addr_o(wb_addr), .wb_data_o(wb_data),
        .csr_o(csr_o), .csr_we_o(csr_we_o)
    );

endmodule

// ==== hdl/mem_writeback.sv ====
`timescale 1ns/1ps
`include "cpu_config.svh"

module mem_writeback (
    input  logic                  clk,
    input  logic                  rst_i,
    input  rv_isa_pkg::word_t     alu_res_i,
    input  rv_isa_pkg::word_t     store_data_i,
    input  rv_isa_pkg::word_t     pc4_i,
    input  rv_isa_pkg::reg_addr_t rd_i,
    input  cpu_ctrl_pkg::wb_sel_t wb_sel_i,
    input  logic                  reg_we_i,
    input  logic                  mem_we_i,
    input  logic                  csr_we_i,
    output logic                  wb_we_o,
    output rv_isa_pkg::reg_addr_t wb_addr_o,
    output rv_isa_pkg::word_t     wb_data_o,
    output rv_isa_pkg::word_t     csr_o,
    output logic                  csr_we_o
);

    rv_isa_pkg::word_t dmem [2**`CORE_DMEM_AWIDTH];

    logic [`CORE_DMEM_AWIDTH-1:0] dmem_addr;
    rv_isa_pkg::word_t            mem_q;
    rv_isa_pkg::word_t            alu_q;
    rv_isa_pkg::word_t            pc4_q;
    cpu_ctrl_pkg::wb_sel_t        wb_sel_q;
    logic                         csr_we_q;

    assign dmem_addr = alu_res_i[`CORE_DMEM_AWIDTH+1:2];  // word addressed

    always_ff @(posedge clk) begin
        if (mem_we_i)
            dmem[dmem_addr] <= store_data_i;
        mem_q <= dmem[dmem_addr];
    end

    // ex/wb register
    always_ff @(posedge clk) begin
        alu_q     <= alu_res_i;
        pc4_q     <= pc4_i;
        wb_addr_o <= rd_i;
        wb_sel_q  <= wb_sel_i;
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            wb_we_o  <= 1'b0;
            csr_we_q <= 1'b0;
        end else begin
            wb_we_o  <= reg_we_i;
            csr_we_q <= csr_we_i;
        end
    end

    always_comb begin
        case (wb_sel_q)
            cpu_ctrl_pkg::MEM: wb_data_o = mem_q;
            cpu_ctrl_pkg::PC4: wb_data_o = pc4_q;
            default:           wb_data_o = alu_q;
        endcase
    end

    // tohost csr, holds rs1 of the last csrrw
    always_ff @(posedge clk) begin
        if (rst_i) begin
            csr_o    <= '0;
            csr_we_o <= 1'b0;
        end else begin
            if (csr_we_q)
                csr_o <= alu_q;
            csr_we_o <= csr_we_q;
        end
    end

endmodule

// ==== hdl/execute_stage.sv ====
`timescale 1ns/1ps

module execute_stage (
    input  logic                      clk,
    input  logic                      rst_i,
    input  rv_isa_pkg::word_t         pc_i,
    input  rv_isa_pkg::word_t         rd1_i,
    input  rv_isa_pkg::word_t         rd2_i,
    input  rv_isa_pkg::word_t         imm_i,
    input  rv_isa_pkg::reg_addr_t     ra1_i,
    input  rv_isa_pkg::reg_addr_t     ra2_i,
    input  rv_isa_pkg::reg_addr_t     rd_i,
    input  cpu_ctrl_pkg::alu_op_t     alu_op_i,
    input  logic                      b_sel_imm_i,
    input  cpu_ctrl_pkg::br_kind_t    br_kind_i,
    input  cpu_ctrl_pkg::wb_sel_t     wb_sel_i,
    input  logic                      reg_we_i,
    input  logic                      mem_we_i,
    input  logic                      csr_we_i,
    input  logic                      wb_we_i,
    input  rv_isa_pkg::reg_addr_t     wb_addr_i,
    input  rv_isa_pkg::word_t         wb_data_i,
    output logic                      redirect_o,
    output rv_isa_pkg::word_t         target_o,
    output rv_isa_pkg::word_t         alu_res_o,
    output rv_isa_pkg::word_t         store_data_o,
    output rv_isa_pkg::word_t         pc4_o,
    output rv_isa_pkg::reg_addr_t     rd_o,
    output cpu_ctrl_pkg::wb_sel_t     wb_sel_o,
    output logic                      reg_we_o,
    output logic                      mem_we_o,
    output logic                      csr_we_o
);

    rv_isa_pkg::word_t      pc_q;
    rv_isa_pkg::word_t      rd1_q;
    rv_isa_pkg::word_t      rd2_q;
    rv_isa_pkg::word_t      imm_q;
    rv_isa_pkg::reg_addr_t  ra1_q;
    rv_isa_pkg::reg_addr_t  ra2_q;
    cpu_ctrl_pkg::alu_op_t  alu_op_q;
    logic                   b_sel_imm_q;
    cpu_ctrl_pkg::br_kind_t br_kind_q;

    cpu_ctrl_pkg::fwd_sel_t fwd_a;
    cpu_ctrl_pkg::fwd_sel_t fwd_b;
    rv_isa_pkg::word_t      op_a;   // rs1 after forwarding
    rv_isa_pkg::word_t      op_b;   // rs2 after forwarding
    rv_isa_pkg::word_t      alu_b;

    // id/ex payload
    always_ff @(posedge clk) begin
        pc_q        <= pc_i;
        rd1_q       <= rd1_i;
        rd2_q       <= rd2_i;
        imm_q       <= imm_i;
        ra1_q       <= ra1_i;
        ra2_q       <= ra2_i;
        rd_o        <= rd_i;
        alu_op_q    <= alu_op_i;
        b_sel_imm_q <= b_sel_imm_i;
        wb_sel_o    <= wb_sel_i;
    end

    // id/ex control, a taken branch squashes the instruction in decode
    always_ff @(posedge clk) begin
        if (rst_i || redirect_o) begin
            br_kind_q <= cpu_ctrl_pkg::NONE;
            reg_we_o  <= 1'b0;
            mem_we_o  <= 1'b0;
            csr_we_o  <= 1'b0;
        end else begin
            br_kind_q <= br_kind_i;
            reg_we_o  <= reg_we_i;
            mem_we_o  <= mem_we_i;
            csr_we_o  <= csr_we_i;
        end
    end

    always_comb begin
        fwd_a = cpu_ctrl_pkg::REG;
        fwd_b = cpu_ctrl_pkg::REG;
        if (wb_we_i && wb_addr_i != '0 && wb_addr_i == ra1_q)
            fwd_a = cpu_ctrl_pkg::WB;
        if (wb_we_i && wb_addr_i != '0 && wb_addr_i == ra2_q)
            fwd_b = cpu_ctrl_pkg::WB;
    end

    assign op_a  = (fwd_a == cpu_ctrl_pkg::WB) ? wb_data_i : rd1_q;
    assign op_b  = (fwd_b == cpu_ctrl_pkg::WB) ? wb_data_i : rd2_q;
    assign alu_b = b_sel_imm_q ? imm_q : op_b;

    always_comb begin
        case (alu_op_q)
            cpu_ctrl_pkg::SUB:    alu_res_o = op_a - alu_b;
            cpu_ctrl_pkg::AND:    alu_res_o = op_a & alu_b;
            cpu_ctrl_pkg::OR:     alu_res_o = op_a | alu_b;
            cpu_ctrl_pkg::XOR:    alu_res_o = op_a ^ alu_b;
            cpu_ctrl_pkg::SLT:    alu_res_o = {31'b0, $signed(op_a) < $signed(alu_b)};
            cpu_ctrl_pkg::PASS_B: alu_res_o = alu_b;
            default:              alu_res_o = op_a + alu_b;  // add, addresses, csrrw
        endcase
    end

    always_comb begin
        case (br_kind_q)
            cpu_ctrl_pkg::BEQ: redirect_o = (op_a == op_b);
            cpu_ctrl_pkg::BNE: redirect_o = (op_a != op_b);
            cpu_ctrl_pkg::JAL: redirect_o = 1'b1;
            default:           redirect_o = 1'b0;
        endcase
    end

    assign target_o     = pc_q + imm_q;
    assign pc4_o        = pc_q + 32'd4;
    assign store_data_o = op_b;

endmodule

// ==== hdl/regfile.sv ====
`timescale 1ns/1ps

module regfile (
    input  logic                  clk,
    input  rv_isa_pkg::reg_addr_t ra1_i,
    input  rv_isa_pkg::reg_addr_t ra2_i,
    output rv_isa_pkg::word_t     rd1_o,
    output rv_isa_pkg::word_t     rd2_o,
    input  logic                  we_i,
    input  rv_isa_pkg::reg_addr_t wa_i,
    input  rv_isa_pkg::word_t     wd_i
);

    rv_isa_pkg::word_t regs [32];

    function automatic rv_isa_pkg::word_t read_port(input rv_isa_pkg::reg_addr_t ra);
        if (ra == '0)
            return '0;
        if (we_i && wa_i == ra)
            return wd_i;  // write-through, producer sits in write-back
        return regs[ra];
    endfunction

    always_comb begin
        rd1_o = read_port(ra1_i);
        rd2_o = read_port(ra2_i);
    end

    always_ff @(posedge clk) begin
        if (we_i)
            regs[wa_i] <= wd_i;  // x0 written but never read back
    end

endmodule

// ==== hdl/decode_unit.sv ====
`timescale 1ns/1ps
`include "cpu_config.svh"

module decode_unit (
    input  rv_isa_pkg::word_t         inst_i,
    output rv_isa_pkg::reg_addr_t     ra1_o,
    output rv_isa_pkg::reg_addr_t     ra2_o,
    output rv_isa_pkg::reg_addr_t     rd_o,
    output rv_isa_pkg::word_t         imm_o,
    output cpu_ctrl_pkg::alu_op_t     alu_op_o,
    output logic                      b_sel_imm_o,
    output cpu_ctrl_pkg::br_kind_t    br_kind_o,
    output cpu_ctrl_pkg::wb_sel_t     wb_sel_o,
    output logic                      reg_we_o,
    output logic                      mem_we_o,
    output logic                      csr_we_o
);

    rv_isa_pkg::opcode_t opcode;
    rv_isa_pkg::funct3_t funct3;
    rv_isa_pkg::word_t   imm_i_type;
    rv_isa_pkg::word_t   imm_s_type;
    rv_isa_pkg::word_t   imm_b_type;
    rv_isa_pkg::word_t   imm_u_type;
    rv_isa_pkg::word_t   imm_j_type;

    assign opcode = rv_isa_pkg::opcode_t'(inst_i[6:0]);
    assign funct3 = inst_i[14:12];
    assign ra1_o  = inst_i[19:15];
    assign ra2_o  = inst_i[24:20];
    assign rd_o   = inst_i[11:7];

    assign imm_i_type = {{20{inst_i[31]}}, inst_i[31:20]};
    assign imm_s_type = {{20{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
    assign imm_b_type = {{19{inst_i[31]}}, inst_i[31], inst_i[7], inst_i[30:25],
                         inst_i[11:8], 1'b0};
    assign imm_u_type = {inst_i[31:12], 12'b0};
    assign imm_j_type = {{11{inst_i[31]}}, inst_i[31], inst_i[19:12], inst_i[20],
                         inst_i[30:21], 1'b0};

    always_comb begin
        // anything not matched below stays a no-op
        imm_o       = '0;
        alu_op_o    = cpu_ctrl_pkg::ADD;
        b_sel_imm_o = 1'b0;
        br_kind_o   = cpu_ctrl_pkg::NONE;
        wb_sel_o    = cpu_ctrl_pkg::ALU;
        reg_we_o    = 1'b0;
        mem_we_o    = 1'b0;
        csr_we_o    = 1'b0;
        case (opcode)
            rv_isa_pkg::OP: begin
                reg_we_o = 1'b1;
                case (funct3)
                    3'b000:  alu_op_o = inst_i[30] ? cpu_ctrl_pkg::SUB : cpu_ctrl_pkg::ADD;
                    3'b010:  alu_op_o = cpu_ctrl_pkg::SLT;
                    3'b100:  alu_op_o = cpu_ctrl_pkg::XOR;
                    3'b110:  alu_op_o = cpu_ctrl_pkg::OR;
                    3'b111:  alu_op_o = cpu_ctrl_pkg::AND;
                    default: reg_we_o = 1'b0;  // shifts, sltu
                endcase
            end
            rv_isa_pkg::OP_IMM: begin
                imm_o       = imm_i_type;
                b_sel_imm_o = 1'b1;
                reg_we_o    = (funct3 == 3'b000);  // addi only
            end
            rv_isa_pkg::LUI: begin
                imm_o       = imm_u_type;
                b_sel_imm_o = 1'b1;
                alu_op_o    = cpu_ctrl_pkg::PASS_B;
                reg_we_o    = 1'b1;
            end
            rv_isa_pkg::LOAD: begin
                imm_o       = imm_i_type;
                b_sel_imm_o = 1'b1;
                wb_sel_o    = cpu_ctrl_pkg::MEM;
                reg_we_o    = (funct3 == 3'b010);  // lw
            end
            rv_isa_pkg::STORE: begin
                imm_o       = imm_s_type;
                b_sel_imm_o = 1'b1;
                mem_we_o    = (funct3 == 3'b010);  // sw
            end
            rv_isa_pkg::BRANCH: begin
                imm_o = imm_b_type;
                if (funct3 == 3'b000)
                    br_kind_o = cpu_ctrl_pkg::BEQ;
                else if (funct3 == 3'b001)
                    br_kind_o = cpu_ctrl_pkg::BNE;
            end
            rv_isa_pkg::JAL: begin
                imm_o     = imm_j_type;
                br_kind_o = cpu_ctrl_pkg::JAL;
                wb_sel_o  = cpu_ctrl_pkg::PC4;
                reg_we_o  = 1'b1;
            end
            rv_isa_pkg::SYSTEM: begin
                // csrrw: rs1 + 0 reaches the csr register, old value not returned
                b_sel_imm_o = 1'b1;
                csr_we_o    = (funct3 == 3'b001) && (inst_i[31:20] == `CORE_TOHOST_CSR);
            end
            default: ;
        endcase
    end

endmodule

// ==== hdl/fetch_stage.sv ====
`timescale 1ns/1ps
`include "cpu_config.svh"

module fetch_stage (
    input  logic                         clk,
    input  logic                         rst_i,
    input  logic                         redirect_i,
    input  rv_isa_pkg::word_t            target_i,
    input  logic                         imem_we_i,
    input  logic [`CORE_IMEM_AWIDTH-1:0] imem_addr_i,
    input  rv_isa_pkg::word_t            imem_wdata_i,
    output rv_isa_pkg::word_t            inst_o,
    output rv_isa_pkg::word_t            pc_o
);

    rv_isa_pkg::word_t imem [2**`CORE_IMEM_AWIDTH];

    rv_isa_pkg::word_t            pc_q;     // pc of the word in inst_o
    rv_isa_pkg::word_t            next_pc;
    logic [`CORE_IMEM_AWIDTH-1:0] imem_raddr;

    // reset holds fetch on the reset vector
    always_comb begin
        if (rst_i)
            next_pc = `CORE_RESET_PC;
        else if (redirect_i)
            next_pc = target_i;   // taken branch or jal from execute
        else
            next_pc = pc_q + 32'd4;
    end

    assign imem_raddr = next_pc[`CORE_IMEM_AWIDTH+1:2];

    always_ff @(posedge clk) begin
        pc_q <= next_pc;
    end

    // program load only while the core is held in reset
    always_ff @(posedge clk) begin
        if (rst_i && imem_we_i)
            imem[imem_addr_i] <= imem_wdata_i;
        inst_o <= imem[imem_raddr];  // synchronous read
    end

    assign pc_o = pc_q;

endmodule

// ==== hdl/cpu_ctrl_pkg.sv ====
package cpu_ctrl_pkg;

    typedef enum logic [2:0] {
        ADD,
        SUB,
        AND,
        OR,
        XOR,
        SLT,     // signed
        PASS_B   // lui
    } alu_op_t;

    // write-back source
    typedef enum logic [1:0] {
        ALU,
        MEM,
        PC4      // jal link value
    } wb_sel_t;

    typedef enum logic [1:0] {
        NONE,
        BEQ,
        BNE,
        JAL
    } br_kind_t;

    typedef enum logic {
        REG,     // value read in decode
        WB       // value forwarded from write-back
    } fwd_sel_t;

endpackage

// ==== hdl/rv_isa_pkg.sv ====
package rv_isa_pkg;

    typedef logic [31:0] word_t;      // data word and byte address
    typedef logic [4:0]  reg_addr_t;  // x0..x31
    typedef logic [2:0]  funct3_t;

    // major opcodes, inst[6:0]
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LUI    = 7'b0110111,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111,
        SYSTEM = 7'b1110011
    } opcode_t;

endpackage

// ==== hdl/cpu_config.svh ====
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// first instruction fetched after reset
`define CORE_RESET_PC 32'h0000_0000

// word-address widths of the two memories
`define CORE_IMEM_AWIDTH 10
`define CORE_DMEM_AWIDTH 10

`define CORE_TOHOST_CSR 12'h51e  // csr driving the core output

`endif
